// File: hw/cache_flush_ctrl.sv
`default_nettype none

module cache_flush_ctrl (
    input  logic CLK,
    input  logic nRST,
    input  logic flush_start,
    output logic iflush_done,
    output logic dflush_done
);

    logic [1:0] done;

    // Index 0 is the instruction cache, index 1 the data cache
    for (genvar i = 0; i < 2; i++) begin : g_flush
        logic [mem_stage_pkg::FLUSH_CNT_W-1:0] cnt;

        // Loaded on the start pulse, then counts down to idle
        always_ff @(posedge CLK, negedge nRST) begin
            if (!nRST) begin
                cnt <= '0;
            end else if (flush_start) begin
                cnt <= mem_stage_pkg::FLUSH_CNT_W'((i == 0) ?
                                                   mem_stage_pkg::IFLUSH_CYCLES :
                                                   mem_stage_pkg::DFLUSH_CYCLES);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end

        // Done while idle
        assign done[i] = (cnt == '0);
    end

    assign iflush_done = done[0];
    assign dflush_done = done[1];

endmodule

`default_nettype wire

// File: hw/data_ram.sv
`default_nettype none

module data_ram (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        ren,
    input  logic        wen,
    input  logic [31:0] addr,
    input  logic [3:0]  byte_en,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        busy
);

    logic [31:0]                          mem [mem_stage_pkg::RAM_WORDS];
    logic [mem_stage_pkg::RAM_WAIT_W-1:0] wait_cnt;
    logic [mem_stage_pkg::RAM_AW-1:0]     word_idx;
    logic                                 req;
    logic                                 done;

    assign word_idx = addr[mem_stage_pkg::RAM_AW+1:2];
    assign req      = ren | wen;

    // Busy from the first cycle of a request until the wait has run out
    assign done = req & (wait_cnt == mem_stage_pkg::RAM_WAIT_W'(mem_stage_pkg::RAM_WAIT));
    assign busy = req & ~done;

    // Wait counter, restarts after completion so a held request repeats
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (!req || done) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Write commits under byte_en on the completing edge
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < mem_stage_pkg::RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen && done) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Read data only valid in the completing cycle
    assign rdata = (ren && done) ? mem[word_idx] : '0;

endmodule

`default_nettype wire

// File: hw/dmem_extender.sv
`default_nettype none

module dmem_extender (
    input  logic [31:0]               dmem_in,
    input  mem_stage_pkg::load_type_t load_type,
    input  logic [1:0]                byte_offset,
    output logic [31:0]               ext_out
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // Byte lane named by the full offset
    always_comb begin
        case (byte_offset)
            2'b00:   byte_lane = dmem_in[7:0];
            2'b01:   byte_lane = dmem_in[15:8];
            2'b10:   byte_lane = dmem_in[23:16];
            default: byte_lane = dmem_in[31:24];
        endcase
    end

    // Halfword lane only depends on offset bit 1
    assign half_lane = byte_offset[1] ? dmem_in[31:16] : dmem_in[15:0];

    // Extension by load type
    always_comb begin
        case (load_type)
            mem_stage_pkg::LB: begin
                ext_out = {{24{byte_lane[7]}}, byte_lane};
            end
            mem_stage_pkg::LBU: begin
                ext_out = {24'h000000, byte_lane};
            end
            mem_stage_pkg::LH: begin
                ext_out = {{16{half_lane[15]}}, half_lane};
            end
            mem_stage_pkg::LHU: begin
                ext_out = {16'h0000, half_lane};
            end
            mem_stage_pkg::LW: begin
                ext_out = dmem_in;
            end
            default: begin
                ext_out = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/mem_stage.sv
`default_nettype none

module mem_stage (
    input  logic                      CLK,
    input  logic                      nRST,
    // Execute/memory pipeline register
    input  logic                      dren,
    input  logic                      dwen,
    input  logic                      ifence,
    input  logic                      halt_in,
    input  logic                      branch,
    input  logic                      prediction,
    input  logic                      branch_taken,
    input  logic                      csr_swap,
    input  logic                      csr_set,
    input  logic                      csr_clr,
    input  logic                      csr_imm,
    input  mem_stage_pkg::load_type_t load_type,
    input  mem_stage_pkg::wsel_t      w_sel,
    input  logic [31:0]               port_out,
    input  logic [31:0]               rs1_data,
    input  logic [31:0]               rs2_data,
    input  logic [31:0]               pc,
    input  logic [31:0]               pc4,
    input  logic [31:0]               imm_u,
    input  logic [4:0]                zimm,
    // Hazard unit controls
    input  logic                      suppress_data,
    input  logic                      ex_mem_stall,
    // CSR file read data
    input  logic [31:0]               csr_rdata,
    // Data bus
    output logic                      mem_ren,
    output logic                      mem_wen,
    output logic [31:0]               daddr,
    output logic [3:0]                byte_en,
    output logic [31:0]               wdata,
    input  logic [31:0]               rdata,
    input  logic                      busy,
    // Cache flush
    output logic                      flush_start,
    input  logic                      iflush_done,
    input  logic                      dflush_done,
    // Hazard flags
    output logic                      mem_busy,
    output logic                      fence_stall,
    output logic                      mal_load,
    output logic                      mal_store,
    output logic                      mispredict,
    output logic                      halt,
    output logic [31:0]               badaddr,
    // CSR write request
    output logic [31:0]               csr_wdata,
    output logic                      csr_valid_write,
    // Writeback
    output logic [31:0]               reg_wdata
);

    logic [1:0]  byte_offset;
    logic        mal_addr;
    logic [31:0] load_ext;
    logic        ifence_q;
    logic        iflushed;
    logic        dflushed;

    assign byte_offset = port_out[1:0];

    // Bus request, held while the pipeline register is stalled
    assign mem_ren = dren & ~suppress_data;
    assign mem_wen = dwen & ~suppress_data;
    assign daddr   = port_out;

    // One lane per byte, low or high pair per halfword
    always_comb begin
        case (load_type)
            mem_stage_pkg::LB, mem_stage_pkg::LBU: begin
                byte_en = 4'b0001 << byte_offset;
            end
            mem_stage_pkg::LH, mem_stage_pkg::LHU: begin
                byte_en = byte_offset[1] ? 4'b1100 : 4'b0011;
            end
            mem_stage_pkg::LW: begin
                byte_en = 4'b1111;
            end
            default: begin
                byte_en = 4'b0000;
            end
        endcase
    end

    // Store data replicated over every lane of its width
    always_comb begin
        case (load_type)
            mem_stage_pkg::LB, mem_stage_pkg::LBU: wdata = {4{rs2_data[7:0]}};
            mem_stage_pkg::LH, mem_stage_pkg::LHU: wdata = {2{rs2_data[15:0]}};
            mem_stage_pkg::LW:                     wdata = rs2_data;
            default:                               wdata = '0;
        endcase
    end

    // Words need offset 0, halfwords an even offset
    always_comb begin
        case (load_type)
            mem_stage_pkg::LW:                     mal_addr = (byte_offset != 2'b00);
            mem_stage_pkg::LH, mem_stage_pkg::LHU: mal_addr = byte_offset[0];
            default:                               mal_addr = 1'b0;
        endcase
    end

    assign mal_load  = dren & mal_addr;
    assign mal_store = dwen & mal_addr;
    assign badaddr   = port_out;

    dmem_extender u_dmem_extender (
        .dmem_in     (rdata),
        .load_type   (load_type),
        .byte_offset (byte_offset),
        .ext_out     (load_ext)
    );

    // Fence tracking
    // The flushed flags drop on the fence edge and then follow the done levels
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ifence_q <= 1'b0;
            iflushed <= 1'b1;
            dflushed <= 1'b1;
        end else begin
            ifence_q <= ifence;
            iflushed <= flush_start ? 1'b0 : iflush_done;
            dflushed <= flush_start ? 1'b0 : dflush_done;
        end
    end

    assign flush_start = ifence & ~ifence_q;

    // Stall covers the start cycle too, before the flags have dropped
    assign fence_stall = ifence & (flush_start | ~iflushed | ~dflushed);
    assign mem_busy    = busy;

    // Branch outcome against prediction
    assign mispredict = branch & (prediction ^ branch_taken);
    assign halt       = halt_in;

    // CSR write request
    assign csr_wdata       = csr_imm ? {27'h0, zimm} : rs1_data;
    assign csr_valid_write = (csr_swap | csr_set | csr_clr) & ~ex_mem_stall;

    // Writeback select
    always_comb begin
        case (w_sel)
            mem_stage_pkg::WSEL_LOAD: reg_wdata = load_ext;
            mem_stage_pkg::WSEL_PC4:  reg_wdata = pc4;
            mem_stage_pkg::WSEL_IMMU: reg_wdata = imm_u;
            mem_stage_pkg::WSEL_ALU:  reg_wdata = port_out;
            mem_stage_pkg::WSEL_CSR:  reg_wdata = csr_rdata;
            default:                  reg_wdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    // Access width and signedness, funct3 encoding of the load opcodes.
    // Stores reuse the width part of the same code.
    typedef enum logic [2:0] {
        LB   = 3'b000,
        LH   = 3'b001,
        LW   = 3'b010,
        LBU  = 3'b100,
        LHU  = 3'b101,
        NONE = 3'b111
    } load_type_t;

    // Writeback source for the register file
    typedef enum logic [2:0] {
        WSEL_LOAD = 3'd0,
        WSEL_PC4  = 3'd1,
        WSEL_IMMU = 3'd2,
        WSEL_ALU  = 3'd3,
        WSEL_CSR  = 3'd4
    } wsel_t;

    // Data RAM
    // Cycles busy stays high before an access completes
    localparam int RAM_WAIT = 1;

    // Width of the RAM wait counter
    localparam int RAM_WAIT_W = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

    // Depth in words, indexed by address bits above the byte offset
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW = $clog2(RAM_WORDS);

    // Cache flush sequences
    // Cycles each done level stays low after a flush start
    localparam int IFLUSH_CYCLES = 3;
    localparam int DFLUSH_CYCLES = 5;

    // Counter width covers the longer of the two sequences
    localparam int FLUSH_CNT_W =
        $clog2(((IFLUSH_CYCLES > DFLUSH_CYCLES) ? IFLUSH_CYCLES : DFLUSH_CYCLES) + 1);

endpackage

`default_nettype wire

// File: hw/mem_subsys.sv
`default_nettype none

module mem_subsys (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      dren,
    input  logic                      dwen,
    input  logic                      ifence,
    input  logic                      halt_in,
    input  logic                      branch,
    input  logic                      prediction,
    input  logic                      branch_taken,
    input  logic                      csr_swap,
    input  logic                      csr_set,
    input  logic                      csr_clr,
    input  logic                      csr_imm,
    input  mem_stage_pkg::load_type_t load_type,
    input  mem_stage_pkg::wsel_t      w_sel,
    input  logic [31:0]               port_out,
    input  logic [31:0]               rs1_data,
    input  logic [31:0]               rs2_data,
    input  logic [31:0]               pc,
    input  logic [31:0]               pc4,
    input  logic [31:0]               imm_u,
    input  logic [4:0]                zimm,
    input  logic                      suppress_data,
    input  logic                      ex_mem_stall,
    input  logic [31:0]               csr_rdata,
    output logic                      mem_busy,
    output logic                      fence_stall,
    output logic                      mal_load,
    output logic                      mal_store,
    output logic                      mispredict,
    output logic                      halt,
    output logic [31:0]               badaddr,
    output logic [31:0]               csr_wdata,
    output logic                      csr_valid_write,
    output logic [31:0]               reg_wdata
);

    // Data bus
    logic        mem_ren;
    logic        mem_wen;
    logic [31:0] daddr;
    logic [3:0]  byte_en;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        busy;

    // Flush path
    logic        flush_start;
    logic        iflush_done;
    logic        dflush_done;

    // Names match the stage ports one to one
    mem_stage u_mem_stage (.*);

    data_ram u_data_ram (
        .CLK     (CLK),
        .nRST    (nRST),
        .ren     (mem_ren),
        .wen     (mem_wen),
        .addr    (daddr),
        .byte_en (byte_en),
        .wdata   (wdata),
        .rdata   (rdata),
        .busy    (busy)
    );

    cache_flush_ctrl u_cache_flush_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .flush_start (flush_start),
        .iflush_done (iflush_done),
        .dflush_done (dflush_done)
    );

endmodule

`default_nettype wire

// File: mem_subsys.f
hw/mem_stage_pkg.sv
hw/dmem_extender.sv
hw/mem_stage.sv
hw/data_ram.sv
hw/cache_flush_ctrl.sv
hw/mem_subsys.sv
tests/tb_clock.sv
tests/mem_subsys_sva.sv
tests/mem_subsys_tb.sv

// File: tests/mem_subsys_sva.sv
`default_nettype none

module mem_subsys_sva (
    input logic       CLK,
    input logic       nRST,
    input logic       mem_ren,
    input logic       mem_wen,
    input logic [3:0] byte_en,
    input logic       busy,
    input logic       suppress_data,
    input logic       fence_stall
);

    localparam int STALL_MAX = mem_stage_pkg::DFLUSH_CYCLES + 2;

    logic [3:0] stall_run;

    // Cycles fence_stall has already been high in a row
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            stall_run <= '0;
        end else if (!fence_stall) begin
            stall_run <= '0;
        end else if (stall_run != 4'hf) begin
            stall_run <= stall_run + 1'b1;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) |-> (byte_en != 4'b0000))
        else $error("byte_en is zero during a bus request");

    // The RAM must not start an access while the hazard unit suppresses it
    assert property (@(posedge CLK) disable iff (!nRST)
        suppress_data |-> !busy)
        else $error("RAM busy while suppress_data is high");

    assert property (@(posedge CLK) disable iff (!nRST)
        fence_stall |-> (stall_run < STALL_MAX))
        else $error("fence_stall held longer than %0d cycles", STALL_MAX);

endmodule

`default_nettype wire

// File: tests/mem_subsys_tb.sv
`default_nettype none

module mem_subsys_tb;

    localparam int N_STORE   = 40;
    localparam int N_LOAD    = 40;
    localparam int N_MAL     = 20;
    localparam int N_SIDE    = 30;
    localparam int WORDS     = mem_stage_pkg::RAM_WORDS;
    localparam int ACC       = mem_stage_pkg::RAM_WAIT + 2;
    localparam int FENCE_LEN = mem_stage_pkg::DFLUSH_CYCLES + 2;
    // Reset, two accesses per store, one per load, one check plus readback per misaligned case
    localparam int CYCLE_LIMIT = 2 * (10 + 2 * N_STORE * ACC + N_LOAD * ACC
                                      + N_MAL * (ACC + 2) + N_SIDE * 2 + 2 * (FENCE_LEN + 3));

    logic CLK, nRST;
    logic dren, dwen, ifence, halt_in, branch, prediction, branch_taken;
    logic csr_swap, csr_set, csr_clr, csr_imm, suppress_data, ex_mem_stall;
    mem_stage_pkg::load_type_t load_type;
    mem_stage_pkg::wsel_t      w_sel;
    logic [31:0] port_out, rs1_data, rs2_data, pc, pc4, imm_u, csr_rdata;
    logic [4:0]  zimm;
    logic mem_busy, fence_stall, mal_load, mal_store, mispredict, halt, csr_valid_write;
    logic [31:0] badaddr, csr_wdata, reg_wdata;

    // Byte-wide reference of the data RAM
    logic [7:0]  model [WORDS * 4];
    logic [31:0] rng_state = 32'd9;
    int checks = 0;
    int errors = 0;
    int cycles = 0;

    mem_stage_pkg::load_type_t load_kinds [5] = '{mem_stage_pkg::LB, mem_stage_pkg::LH,
        mem_stage_pkg::LW, mem_stage_pkg::LBU, mem_stage_pkg::LHU};
    mem_stage_pkg::wsel_t side_sels [4] = '{mem_stage_pkg::WSEL_PC4, mem_stage_pkg::WSEL_IMMU,
        mem_stage_pkg::WSEL_ALU, mem_stage_pkg::WSEL_CSR};

    tb_clock u_tb_clock (.CLK(CLK), .nRST(nRST));

    mem_subsys u_mem_subsys (.*);

    bind mem_stage mem_subsys_sva u_mem_subsys_sva (.*);

    function automatic logic [31:0] xorshift();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [31:0] model_word(input int idx);
        return {model[4*idx+3], model[4*idx+2], model[4*idx+1], model[4*idx]};
    endfunction

    // Lane of the reference word, extended per load type
    function automatic logic [31:0] expected_load(input int idx, input logic [1:0] off,
                                                  input mem_stage_pkg::load_type_t lt);
        int base;
        base = 4 * idx + int'(off);
        case (lt)
            mem_stage_pkg::LB:  return {{24{model[base][7]}}, model[base]};
            mem_stage_pkg::LBU: return {24'h0, model[base]};
            mem_stage_pkg::LH:  return {{16{model[base+1][7]}}, model[base+1], model[base]};
            mem_stage_pkg::LHU: return {16'h0, model[base+1], model[base]};
            default:            return model_word(idx);
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Holds the request until busy drops, returns the writeback value of that cycle
    task automatic bus_access(input logic wr, input logic [31:0] addr,
                              input mem_stage_pkg::load_type_t lt, input logic [31:0] wd,
                              output logic [31:0] rd);
        port_out = addr;
        load_type = lt;
        rs2_data = wd;
        w_sel = mem_stage_pkg::WSEL_LOAD;
        dren = !wr;
        dwen = wr;
        do @(negedge CLK); while (mem_busy);
        rd = reg_wdata;
        @(posedge CLK);
        #1;
        dren = 1'b0;
        dwen = 1'b0;
    endtask

    always @(posedge CLK) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int err0;
        int idx;
        int k;
        int len;
        int size;
        bit wr;
        bit mis;
        logic [1:0]  off;
        logic [31:0] r;
        logic [31:0] wd;
        logic [31:0] rd;
        mem_stage_pkg::load_type_t lt;

        {dren, dwen, ifence, halt_in, branch, prediction, branch_taken, csr_swap, csr_set,
         csr_clr, csr_imm, suppress_data, ex_mem_stall} = '0;
        {port_out, rs1_data, rs2_data, pc, pc4, imm_u, csr_rdata} = '0;
        zimm = '0;
        load_type = mem_stage_pkg::LW;
        w_sel = mem_stage_pkg::WSEL_LOAD;
        for (int i = 0; i < WORDS * 4; i++) begin
            model[i] = 8'h00;
        end
        @(posedge nRST);
        @(posedge CLK);
        #1;

        // Stores of each width, then a word readback
        err0 = errors;
        for (int n = 0; n < N_STORE; n++) begin
            r = xorshift();
            wd = xorshift();
            idx = int'(r >> 8) % WORDS;
            k = int'(r[1:0]) % 3;
            lt = (k == 0) ? mem_stage_pkg::LB : (k == 1) ? mem_stage_pkg::LH : mem_stage_pkg::LW;
            off = (k == 0) ? r[3:2] : (k == 1) ? {r[2], 1'b0} : 2'b00;
            bus_access(1'b1, 32'(idx * 4) + 32'(off), lt, wd, rd);
            for (int b = 0; b < 4; b++) begin
                if (k == 2 || b == int'(off) || (k == 1 && b == int'(off) + 1)) begin
                    model[4*idx+b] = wd[8*(b - int'(off)) +: 8];
                end
            end
            bus_access(1'b0, 32'(idx * 4), mem_stage_pkg::LW, 32'h0, rd);
            compare_value("store_readback", model_word(idx), rd);
        end
        $display("store_readback: %0d errors", errors - err0);

        err0 = errors;
        for (int n = 0; n < N_LOAD; n++) begin
            r = xorshift();
            idx = int'(r >> 8) % WORDS;
            lt = load_kinds[int'(r[2:0]) % 5];
            off = r[4:3];
            if (lt == mem_stage_pkg::LH || lt == mem_stage_pkg::LHU) begin
                off[0] = 1'b0;
            end else if (lt == mem_stage_pkg::LW) begin
                off = 2'b00;
            end
            bus_access(1'b0, 32'(idx * 4) + 32'(off), lt, 32'h0, rd);
            compare_value("load_extend", expected_load(idx, off, lt), rd);
        end
        $display("load_extend: %0d errors", errors - err0);

        // Halfword and word accesses at any offset with the request suppressed
        err0 = errors;
        for (int n = 0; n < N_MAL; n++) begin
            r = xorshift();
            idx = int'(r >> 8) % WORDS;
            k = int'(r[1:0]) % 3;
            lt = (k == 2) ? mem_stage_pkg::LW : (k == 1) ? mem_stage_pkg::LHU : mem_stage_pkg::LH;
            off = r[3:2];
            wr = r[4];
            port_out = 32'(idx * 4) + 32'(off);
            load_type = lt;
            rs2_data = xorshift();
            dren = !wr;
            dwen = wr;
            suppress_data = 1'b1;
            @(negedge CLK);
            // Misaligned when the address is not a multiple of the access size
            size = (lt == mem_stage_pkg::LW) ? 4 : 2;
            mis = (int'(off) % size) != 0;
            compare_value("mal_load", 32'(mis & !wr), 32'(mal_load));
            compare_value("mal_store", 32'(mis & wr), 32'(mal_store));
            compare_value("badaddr", port_out, badaddr);
            compare_value("mal_no_busy", 32'h0, 32'(mem_busy));
            @(posedge CLK);
            #1;
            suppress_data = 1'b0;
            dren = 1'b0;
            dwen = 1'b0;
            bus_access(1'b0, 32'(idx * 4), mem_stage_pkg::LW, 32'h0, rd);
            compare_value("mal_unchanged", model_word(idx), rd);
        end
        $display("misaligned: %0d errors", errors - err0);

        err0 = errors;
        for (int n = 0; n < N_SIDE; n++) begin
            r = xorshift();
            w_sel = side_sels[int'(r[1:0])];
            {csr_swap, csr_set, csr_clr, csr_imm, ex_mem_stall} = r[6:2];
            {branch, prediction, branch_taken, halt_in} = r[10:7];
            zimm = r[15:11];
            pc4 = xorshift();
            imm_u = xorshift();
            port_out = xorshift();
            csr_rdata = xorshift();
            rs1_data = xorshift();
            @(negedge CLK);
            case (w_sel)
                mem_stage_pkg::WSEL_PC4:  wd = pc4;
                mem_stage_pkg::WSEL_IMMU: wd = imm_u;
                mem_stage_pkg::WSEL_ALU:  wd = port_out;
                default:                  wd = csr_rdata;
            endcase
            compare_value("wb_select", wd, reg_wdata);
            // Immediate form takes zimm zero-extended, register form takes rs1
            if (csr_imm) begin
                wd = 32'(zimm);
            end else begin
                wd = rs1_data;
            end
            compare_value("csr_wdata", wd, csr_wdata);
            compare_value("csr_valid", 32'((csr_swap || csr_set || csr_clr) && !ex_mem_stall),
                          32'(csr_valid_write));
            compare_value("mispredict", 32'(branch && (prediction != branch_taken)),
                          32'(mispredict));
            compare_value("halt", 32'(halt_in), 32'(halt));
            @(posedge CLK);
            #1;
        end
        $display("side_outputs: %0d errors", errors - err0);

        // Two fences, each held until the stall falls
        err0 = errors;
        for (int f = 0; f < 2; f++) begin
            ifence = 1'b1;
            len = 0;
            @(negedge CLK);
            while (fence_stall) begin
                len++;
                @(negedge CLK);
            end
            compare_value("fence_stall_len", FENCE_LEN, len);
            @(posedge CLK);
            #1;
            ifence = 1'b0;
            @(posedge CLK);
            #1;
        end
        $display("fence_stall: %0d errors", errors - err0);

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Release just after the fifth rising edge
    initial begin
        nRST = 1'b0;
        repeat (5) @(posedge CLK);
        #1 nRST = 1'b1;
    end

endmodule

`default_nettype wire
